// File: build.f
rtl/eth_tx_pkg.sv
rtl/csum_cmd_if.sv
rtl/txc_decode.sv
rtl/stream_fifo.sv
rtl/csum_engine.sv
rtl/csum_insert.sv
rtl/axi_eth_tx.sv
dv/tb_axi_eth_tx.sv

// File: dv/tb_axi_eth_tx.sv
`timescale 1ns/1ns

module tb_axi_eth_tx;
   import eth_tx_pkg::*;

   localparam int WAIT_LIMIT = 4000;
   localparam int FRAME_LENS [8] = '{1, 64, 9, 2, 17, 64, 3, 30};

   logic        mm2s_clk;
   logic        rst;
   logic [31:0] txc_tdata;
   logic [3:0]  txc_tkeep;
   logic        txc_tlast;
   logic        txc_tvalid;
   logic        txc_tready;
   logic [63:0] txd_tdata;
   logic [7:0]  txd_tkeep;
   logic        txd_tlast;
   logic        txd_tvalid;
   logic        txd_tready;
   logic [63:0] tx_tdata;
   logic [7:0]  tx_tkeep;
   logic        tx_tlast;
   logic        tx_tvalid;
   logic        tx_tready;

   // Frame being built with lane 0 of beat 0 as frame byte 0
   logic [63:0] frm_data [FRAME_BEATS_MAX];
   logic [7:0]  frm_keep [FRAME_BEATS_MAX];
   // Expected MAC beats as {data, keep, last}
   logic [72:0] exp_q [$];
   logic [72:0] exp_beat;
   logic [31:0] lfsr;
   logic        stall_mode;
   int          out_cnt;

   axi_eth_tx i_axi_eth_tx (.*);

   always #20 mm2s_clk = ~mm2s_clk;

   task automatic abort_run(input string line);
      $display("%s", line);
      $display("SIMULATION FAILED");
      $fatal(1);
   endtask

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [7:0] frame_byte(input int off, input int begin_off);
      if (off < begin_off || !frm_keep[off / 8][off % 8]) begin
         return 8'h00;
      end
      return frm_data[off / 8][8 * (off % 8) +: 8];
   endfunction

   // Ones' complement sum over the whole frame built byte by byte
   function automatic logic [15:0] model_csum(input int nbeats, input int begin_off,
                                              input logic [15:0] init);
      logic [31:0] sum;
      sum = {16'd0, init};
      for (int k = 0; k < 8 * nbeats; k += 2) begin
         sum = sum + {16'd0, frame_byte(k, begin_off), frame_byte(k + 1, begin_off)};
      end
      while (sum[31:16] != 16'd0) begin
         sum = {16'd0, sum[15:0]} + {16'd0, sum[31:16]};
      end
      return ~sum[15:0];
   endfunction

   task automatic queue_expected(input logic enable, input int insert_off,
                                 input logic [15:0] csum, input int nbeats);
      logic [63:0] d;
      for (int b = 0; b < nbeats; b++) begin
         d = frm_data[b];
         if (enable && b == insert_off / 8) begin
            d[8 * (insert_off % 8) +: 8]     = csum[15:8];
            d[8 * (insert_off % 8) + 8 +: 8] = csum[7:0];
         end
         exp_q.push_back({d, frm_keep[b], b == nbeats - 1});
      end
   endtask

   task automatic fill_incrementing(input int nbeats, input logic [7:0] first);
      for (int k = 0; k < 8 * nbeats; k++) begin
         frm_data[k / 8][8 * (k % 8) +: 8] = first + 8'(k);
      end
      for (int b = 0; b < nbeats; b++) begin
         frm_keep[b] = 8'hFF;
      end
   endtask

   // Ethernet, IPv4 and TCP headers of a SYN with the TCP checksum field zeroed
   task automatic fill_tcp_syn();
      logic [63:0] rows [7];
      rows = '{64'h0011223344556677, 64'h8899aabb08004500, 64'h0028123440004006,
               64'h0000c0a80001c0a8, 64'h0002303900500000, 64'h0001000000005002,
               64'h2000000000000000};
      // Rows are in wire order and the leftmost byte goes to lane 0
      for (int b = 0; b < 7; b++) begin
         for (int l = 0; l < 8; l++) begin
            frm_data[b][8 * l +: 8] = rows[b][63 - 8 * l -: 8];
         end
         frm_keep[b] = 8'hFF;
      end
      frm_keep[6] = 8'h3F;
   endtask

   // Ready has no path from valid, so it is settled after the falling edge
   task automatic push_ctrl(input logic [31:0] word, input logic last);
      int waited;
      txc_tdata  = word;
      txc_tkeep  = 4'hF;
      txc_tlast  = last;
      txc_tvalid = 1'b1;
      waited     = 0;
      while (!txc_tready) begin
         @(negedge mm2s_clk);
         waited++;
         if (waited > WAIT_LIMIT) begin
            abort_run("Timeout: a control word was never accepted");
         end
      end
      @(negedge mm2s_clk);
      txc_tvalid = 1'b0;
   endtask

   task automatic push_data(input logic [63:0] data, input logic [7:0] keep, input logic last);
      int waited;
      txd_tdata  = data;
      txd_tkeep  = keep;
      txd_tlast  = last;
      txd_tvalid = 1'b1;
      waited     = 0;
      while (!txd_tready) begin
         @(negedge mm2s_clk);
         waited++;
         if (waited > WAIT_LIMIT) begin
            abort_run("Timeout: a data beat was never accepted");
         end
      end
      @(negedge mm2s_clk);
      txd_tvalid = 1'b0;
   endtask

   task automatic send_frame(input logic [1:0] ctrl, input int begin_off, input int insert_off,
                             input logic [15:0] init, input int nbeats);
      queue_expected(ctrl[0], insert_off, model_csum(nbeats, begin_off, init), nbeats);
      push_ctrl({CTRL_FLAG, 28'd0}, 1'b0);
      push_ctrl({30'd0, ctrl}, 1'b0);
      push_ctrl({16'(begin_off), 16'(insert_off)}, 1'b0);
      push_ctrl({16'd0, init}, 1'b0);
      push_ctrl(32'd0, 1'b0);
      push_ctrl(32'd0, 1'b1);
      for (int b = 0; b < nbeats; b++) begin
         push_data(frm_data[b], frm_keep[b], b == nbeats - 1);
      end
   endtask

   // MAC backpressure with one LFSR step per ready bit
   always @(negedge mm2s_clk) begin
      if (stall_mode) begin
         lfsr      = lfsr_next(lfsr);
         tx_tready = lfsr[0];
      end else begin
         tx_tready = 1'b1;
      end
   end

   // Scoreboard on every MAC transfer
   always @(posedge mm2s_clk) begin
      if (!rst && tx_tvalid && tx_tready) begin
         a_beat_queued: assert (exp_q.size() != 0) else
            abort_run("The MAC stream sent a beat that no frame accounts for");
         exp_beat = exp_q.pop_front();
         a_beat_data: assert (tx_tdata == exp_beat[72:9]) else
            abort_run($sformatf("** Error at %0t ns: beat %0d data %h, expected %h",
                                $time, out_cnt, tx_tdata, exp_beat[72:9]));
         a_beat_keep: assert (tx_tkeep == exp_beat[8:1]) else
            abort_run($sformatf("** Error at %0t ns: beat %0d keep %h, expected %h",
                                $time, out_cnt, tx_tkeep, exp_beat[8:1]));
         a_beat_last: assert (tx_tlast == exp_beat[0]) else
            abort_run($sformatf("** Error at %0t ns: beat %0d last %b, expected %b",
                                $time, out_cnt, tx_tlast, exp_beat[0]));
         out_cnt++;
      end
   end

   initial begin
      int waited;
      mm2s_clk   = 1'b0;
      rst        = 1'b1;
      txc_tdata  = '0;
      txc_tkeep  = '0;
      txc_tlast  = 1'b0;
      txc_tvalid = 1'b0;
      txd_tdata  = '0;
      txd_tkeep  = '0;
      txd_tlast  = 1'b0;
      txd_tvalid = 1'b0;
      tx_tready  = 1'b0;
      lfsr       = 32'h7072;
      stall_mode = 1'b0;
      out_cnt    = 0;
      repeat (4) @(negedge mm2s_clk);
      rst = 1'b0;

      a_reset_idle: assert (!tx_tvalid && !txd_tready && txc_tready) else
         abort_run($sformatf("** Error at %0t ns: idle tx_tvalid %b txd_tready %b txc_tready %b",
                             $time, tx_tvalid, txd_tready, txc_tready));

      // Checksum off so frames pass untouched
      for (int n = 32; n <= 34; n++) begin
         fill_incrementing(n, 8'(n));
         send_frame(2'b00, 0, 10, 16'h0000, n);
      end

      fill_tcp_syn();
      send_frame(2'b01, 34, 50, 16'h0000, 7);

      // 37 bytes with junk in the dropped lanes
      fill_incrementing(5, 8'h41);
      frm_keep[4]        = 8'h1F;
      frm_data[4][63:40] = 24'hdeadbe;
      send_frame(2'b01, 14, 16, 16'h1234, 5);

      stall_mode = 1'b1;
      for (int f = 0; f < 8; f++) begin
         fill_incrementing(FRAME_LENS[f], 8'(f * 29));
         send_frame({1'(f % 2), 1'(f != 3)}, f * 5, 2 * ((f * 11) % (FRAME_LENS[f] * 4)),
                    16'hffff - 16'(f * 4097), FRAME_LENS[f]);
      end

      waited = 0;
      while (exp_q.size() != 0) begin
         @(negedge mm2s_clk);
         waited++;
         if (waited > WAIT_LIMIT) begin
            abort_run($sformatf("Timeout: %0d expected beats never reached the MAC stream",
                                exp_q.size()));
         end
      end

      // Nothing may follow the last expected beat
      if (!tx_tvalid && !txd_tready && txc_tready) begin
         $display("SIMULATION PASSED");
         $finish;
      end else begin
         abort_run($sformatf(
            "** Error at %0t ns: busy after %0d beats, tx_tvalid %b txd_tready %b txc_tready %b",
            $time, out_cnt, tx_tvalid, txd_tready, txc_tready));
      end
   end

endmodule

// File: rtl/axi_eth_tx.sv
`timescale 1ns/1ns

module axi_eth_tx (
   input  logic                                mm2s_clk,
   input  logic                                rst,
   input  logic [31:0]                         txc_tdata,
   input  logic [3:0]                          txc_tkeep,
   input  logic                                txc_tlast,
   input  logic                                txc_tvalid,
   output logic                                txc_tready,
   input  logic [8*eth_tx_pkg::DATA_BYTES-1:0] txd_tdata,
   input  logic [eth_tx_pkg::DATA_BYTES-1:0]   txd_tkeep,
   input  logic                                txd_tlast,
   input  logic                                txd_tvalid,
   output logic                                txd_tready,
   output logic [8*eth_tx_pkg::DATA_BYTES-1:0] tx_tdata,
   output logic [eth_tx_pkg::DATA_BYTES-1:0]   tx_tkeep,
   output logic                                tx_tlast,
   output logic                                tx_tvalid,
   input  logic                                tx_tready
);
   import eth_tx_pkg::*;

   data_beat_t   beat_in;
   logic         beat_in_valid;
   logic         beat_in_ready;
   data_beat_t   beat_out;
   logic         beat_out_valid;
   logic         beat_out_ready;
   csum_result_t res_in;
   logic         res_in_valid;
   logic         res_in_ready;
   csum_result_t res_out;
   logic         res_out_valid;
   logic         res_out_ready;

   csum_cmd_if cmd_bus ();

   txc_decode i_txc_decode (
      .mm2s_clk   (mm2s_clk),
      .rst        (rst),
      .txc_tdata  (txc_tdata),
      .txc_tkeep  (txc_tkeep),
      .txc_tlast  (txc_tlast),
      .txc_tvalid (txc_tvalid),
      .txc_tready (txc_tready),
      .cmd        (cmd_bus.source)
   );

   csum_engine i_csum_engine (
      .mm2s_clk   (mm2s_clk),
      .rst        (rst),
      .cmd        (cmd_bus.sink),
      .txd_tdata  (txd_tdata),
      .txd_tkeep  (txd_tkeep),
      .txd_tlast  (txd_tlast),
      .txd_tvalid (txd_tvalid),
      .txd_tready (txd_tready),
      .beat_data  (beat_in),
      .beat_valid (beat_in_valid),
      .beat_ready (beat_in_ready),
      .res_data   (res_in),
      .res_valid  (res_in_valid),
      .res_ready  (res_in_ready)
   );

   // Whole-frame buffer while the checksum is still open
   stream_fifo #(.payload_t(data_beat_t), .DEPTH(FRAME_BEATS_MAX)) i_beat_fifo (
      .mm2s_clk  (mm2s_clk),
      .rst       (rst),
      .in_data   (beat_in),
      .in_valid  (beat_in_valid),
      .in_ready  (beat_in_ready),
      .out_data  (beat_out),
      .out_valid (beat_out_valid),
      .out_ready (beat_out_ready)
   );

   stream_fifo #(.payload_t(csum_result_t), .DEPTH(RESULT_DEPTH)) i_res_fifo (
      .mm2s_clk  (mm2s_clk),
      .rst       (rst),
      .in_data   (res_in),
      .in_valid  (res_in_valid),
      .in_ready  (res_in_ready),
      .out_data  (res_out),
      .out_valid (res_out_valid),
      .out_ready (res_out_ready)
   );

   csum_insert i_csum_insert (
      .mm2s_clk   (mm2s_clk),
      .rst        (rst),
      .res_data   (res_out),
      .res_valid  (res_out_valid),
      .res_ready  (res_out_ready),
      .beat_data  (beat_out),
      .beat_valid (beat_out_valid),
      .beat_ready (beat_out_ready),
      .tx_tdata   (tx_tdata),
      .tx_tkeep   (tx_tkeep),
      .tx_tlast   (tx_tlast),
      .tx_tvalid  (tx_tvalid),
      .tx_tready  (tx_tready)
   );

endmodule

// File: rtl/csum_cmd_if.sv
`timescale 1ns/1ns

// Decoded checksum command handed from the control decoder to the engine
interface csum_cmd_if;
   import eth_tx_pkg::*;

   logic      valid;
   logic      ready;
   csum_cmd_t data;

   // Decoder side
   modport source (
      output valid,
      output data,
      input  ready
   );

   // Engine side, ready doubles as the release of the command
   modport sink (
      input  valid,
      input  data,
      output ready
   );

endinterface

// File: rtl/csum_engine.sv
`timescale 1ns/1ns

module csum_engine (
   input  logic                                mm2s_clk,
   input  logic                                rst,
   csum_cmd_if.sink                            cmd,
   input  logic [8*eth_tx_pkg::DATA_BYTES-1:0] txd_tdata,
   input  logic [eth_tx_pkg::DATA_BYTES-1:0]   txd_tkeep,
   input  logic                                txd_tlast,
   input  logic                                txd_tvalid,
   output logic                                txd_tready,
   output eth_tx_pkg::data_beat_t              beat_data,
   output logic                                beat_valid,
   input  logic                                beat_ready,
   output eth_tx_pkg::csum_result_t            res_data,
   output logic                                res_valid,
   input  logic                                res_ready
);
   import eth_tx_pkg::*;

   logic [$clog2(FRAME_BEATS_MAX)-1:0] beat_cnt;
   logic [15:0]                        beat_off;
   logic [DATA_BYTES-1:0]              byte_en;
   logic [31:0]                        beat_sum;
   logic [31:0]                        acc;
   logic [31:0]                        acc_next;
   logic [16:0]                        fold1;
   logic [15:0]                        fold2;
   logic                               accept;

   // Data flows only against a held command, with room for beat and result
   assign txd_tready = cmd.valid && beat_ready && res_ready;
   assign accept     = txd_tvalid && txd_tready;

   // Frame byte offset of lane 0
   assign beat_off = 16'(beat_cnt) * 16'(DATA_BYTES);

   always_comb begin
      beat_sum = '0;
      for (int i = 0; i < DATA_BYTES; i++) begin
         byte_en[i] = cmd.data.enable && txd_tkeep[i] &&
                      (beat_off + 16'(i) >= cmd.data.begin_off);
      end
      // Even lane is the high byte, excluded bytes read as zero
      for (int i = 0; i < DATA_BYTES; i += 2) begin
         beat_sum = beat_sum + {16'd0,
                                txd_tdata[8*i +: 8] & {8{byte_en[i]}},
                                txd_tdata[8*i+8 +: 8] & {8{byte_en[i+1]}}};
      end
   end

   // First beat seeds from the initial checksum
   assign acc_next = ((beat_cnt == '0) ? {16'd0, cmd.data.init} : acc) + beat_sum;

   // Two folds cover any sum of a 64-beat frame
   assign fold1 = {1'b0, acc_next[15:0]} + {1'b0, acc_next[31:16]};
   assign fold2 = fold1[15:0] + {15'd0, fold1[16]};

   always_ff @(posedge mm2s_clk) begin
      if (rst) begin
         beat_cnt <= '0;
      end else if (accept) begin
         beat_cnt <= txd_tlast ? '0 : beat_cnt + 1'b1;
      end
   end

   always_ff @(posedge mm2s_clk) begin
      if (accept) begin
         acc <= acc_next;
      end
   end

   assign beat_valid = accept;
   assign beat_data  = '{data: txd_tdata, keep: txd_tkeep, last: txd_tlast};

   // Result and command release share the last-beat edge
   assign res_valid = accept && txd_tlast;
   assign res_data  = '{enable: cmd.data.enable,
                        insert_off: cmd.data.insert_off,
                        csum: ~fold2};
   assign cmd.ready = accept && txd_tlast;

   // Checksum bytes must sit in one lane pair
   a_insert_even: assert property (@(posedge mm2s_clk) disable iff (rst)
      (cmd.valid && cmd.data.enable) |-> !cmd.data.insert_off[0]);

   // Frame must end before the beat counter wraps
   a_frame_len: assert property (@(posedge mm2s_clk) disable iff (rst)
      (accept && beat_cnt == FRAME_BEATS_MAX - 1) |-> txd_tlast);

endmodule

// File: rtl/csum_insert.sv
`timescale 1ns/1ns

module csum_insert (
   input  logic                                mm2s_clk,
   input  logic                                rst,
   input  eth_tx_pkg::csum_result_t            res_data,
   input  logic                                res_valid,
   output logic                                res_ready,
   input  eth_tx_pkg::data_beat_t              beat_data,
   input  logic                                beat_valid,
   output logic                                beat_ready,
   output logic [8*eth_tx_pkg::DATA_BYTES-1:0] tx_tdata,
   output logic [eth_tx_pkg::DATA_BYTES-1:0]   tx_tkeep,
   output logic                                tx_tlast,
   output logic                                tx_tvalid,
   input  logic                                tx_tready
);
   import eth_tx_pkg::*;

   logic [$clog2(FRAME_BEATS_MAX)-1:0] beat_cnt;
   logic [$clog2(DATA_BYTES)-1:0]      ins_lane;
   logic                               ins_hit;
   logic                               take;
   logic                               out_load;
   logic                               skid_load;
   logic                               skid_valid;
   data_beat_t                         patched;
   data_beat_t                         out_beat;
   data_beat_t                         skid_beat;

   // Frame beats move only once their checksum is known
   assign beat_ready = res_valid && !skid_valid;
   assign take       = beat_valid && beat_ready;
   assign res_ready  = take && beat_data.last;

   assign out_load  = !tx_tvalid || tx_tready;
   assign skid_load = take && !out_load;

   // Beat index and lane of the insert offset
   assign ins_lane = res_data.insert_off[$clog2(DATA_BYTES)-1:0];
   assign ins_hit  = res_data.enable &&
                     (16'(beat_cnt) == (res_data.insert_off >> $clog2(DATA_BYTES)));

   always_comb begin
      patched = beat_data;
      for (int i = 0; i < DATA_BYTES; i += 2) begin
         if (ins_hit && int'(ins_lane) == i) begin
            patched.data[8*i +: 8]   = res_data.csum[15:8];
            patched.data[8*i+8 +: 8] = res_data.csum[7:0];
         end
      end
   end

   always_ff @(posedge mm2s_clk) begin
      if (rst) begin
         beat_cnt   <= '0;
         tx_tvalid  <= 1'b0;
         skid_valid <= 1'b0;
      end else begin
         if (take) begin
            beat_cnt <= beat_data.last ? '0 : beat_cnt + 1'b1;
         end
         if (out_load) begin
            tx_tvalid  <= skid_valid || take;
            skid_valid <= 1'b0;
         end else if (take) begin
            skid_valid <= 1'b1;
         end
      end
   end

   // Skid beat drains first so order is kept
   always_ff @(posedge mm2s_clk) begin
      if (out_load) begin
         out_beat <= skid_valid ? skid_beat : patched;
      end
      if (skid_load) begin
         skid_beat <= patched;
      end
   end

   assign tx_tdata = out_beat.data;
   assign tx_tkeep = out_beat.keep;
   assign tx_tlast = out_beat.last;

   // Checksum position must fall inside its frame
   a_insert_in_frame: assert property (@(posedge mm2s_clk) disable iff (rst)
      (res_valid && res_ready && res_data.enable) |->
         (16'(beat_cnt) >= (res_data.insert_off >> $clog2(DATA_BYTES))));

endmodule

// File: rtl/eth_tx_pkg.sv
package eth_tx_pkg;

   // Stream geometry
   localparam int DATA_BYTES = 8;
   localparam int CTRL_WORDS = 6;

   // Flag nibble in bits 31:28 of control word 0
   localparam logic [3:0] CTRL_FLAG = 4'hA;

   // Buffering between engine and inserter
   localparam int FRAME_BEATS_MAX = 64;
   localparam int RESULT_DEPTH    = 4;

   // One data beat, lane 0 is the earliest byte
   typedef struct packed {
      logic [8*DATA_BYTES-1:0] data;
      logic [DATA_BYTES-1:0]   keep;
      logic                    last;
   } data_beat_t;

   // Decoded checksum command, one per frame
   typedef struct packed {
      logic        enable;
      logic [15:0] begin_off;
      logic [15:0] insert_off;
      logic [15:0] init;
   } csum_cmd_t;

   // Finished checksum waiting for its frame
   typedef struct packed {
      logic        enable;
      logic [15:0] insert_off;
      logic [15:0] csum;
   } csum_result_t;

endpackage

// File: rtl/stream_fifo.sv
`timescale 1ns/1ns

module stream_fifo #(
   parameter type payload_t = logic,
   parameter int  DEPTH     = 4
) (
   input  logic     mm2s_clk,
   input  logic     rst,
   input  payload_t in_data,
   input  logic     in_valid,
   output logic     in_ready,
   output payload_t out_data,
   output logic     out_valid,
   input  logic     out_ready
);

   payload_t                     mem [DEPTH];
   logic [$clog2(DEPTH)-1:0]     wr_ptr;
   logic [$clog2(DEPTH)-1:0]     rd_ptr;
   logic [$clog2(DEPTH+1)-1:0]   count;
   logic                         wr_en;
   logic                         rd_en;

   assign in_ready  = (int'(count) != DEPTH);
   assign out_valid = (count != '0);
   assign out_data  = mem[rd_ptr];
   assign wr_en     = in_valid && in_ready;
   assign rd_en     = out_valid && out_ready;

   always_ff @(posedge mm2s_clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= in_data;
      end
   end

   always_ff @(posedge mm2s_clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         // Pointers wrap explicitly so DEPTH need not be a power of two
         if (wr_en) begin
            wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
         end
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Writers here push only into free space
   a_no_overflow: assert property (@(posedge mm2s_clk) disable iff (rst)
      in_valid |-> in_ready);

   // Equal pointers mean empty or full
   a_ptr_count: assert property (@(posedge mm2s_clk) disable iff (rst)
      (wr_ptr == rd_ptr) |-> (count == '0 || int'(count) == DEPTH));

endmodule

// File: rtl/txc_decode.sv
`timescale 1ns/1ns

module txc_decode (
   input  logic        mm2s_clk,
   input  logic        rst,
   input  logic [31:0] txc_tdata,
   input  logic [3:0]  txc_tkeep,
   input  logic        txc_tlast,
   input  logic        txc_tvalid,
   output logic        txc_tready,
   csum_cmd_if.source  cmd
);
   import eth_tx_pkg::*;

   logic [$clog2(CTRL_WORDS)-1:0] word_cnt;
   logic                          word_fire;

   // Stall the control stream while a command waits for the engine
   assign txc_tready = !cmd.valid;
   assign word_fire  = txc_tvalid && txc_tready;

   always_ff @(posedge mm2s_clk) begin
      if (rst) begin
         word_cnt  <= '0;
         cmd.valid <= 1'b0;
      end else begin
         if (word_fire) begin
            if (txc_tlast) begin
               word_cnt <= '0;
            end else begin
               word_cnt <= word_cnt + 1'b1;
            end
         end

         // Command complete after the final word
         if (word_fire && word_cnt == CTRL_WORDS - 1) begin
            cmd.valid <= 1'b1;
         end else if (cmd.valid && cmd.ready) begin
            cmd.valid <= 1'b0;
         end
      end
   end

   // Field capture, words 0, 4 and 5 carry nothing here
   always_ff @(posedge mm2s_clk) begin
      if (word_fire) begin
         case (word_cnt)
            1: begin
               cmd.data.enable <= txc_tdata[0];
            end
            2: begin
               cmd.data.begin_off  <= txc_tdata[31:16];
               cmd.data.insert_off <= txc_tdata[15:0];
            end
            3: begin
               cmd.data.init <= txc_tdata[15:0];
            end
            default: begin
            end
         endcase
      end
   end

   // Word 0 must carry the flag nibble with all lanes kept
   a_ctrl_flag: assert property (@(posedge mm2s_clk) disable iff (rst)
      (word_fire && word_cnt == 0) |->
         (txc_tdata[31:28] == CTRL_FLAG && txc_tkeep == 4'hF));

   // Upstream framing: last on word 5 and nowhere else
   a_ctrl_last: assert property (@(posedge mm2s_clk) disable iff (rst)
      word_fire |-> (txc_tlast == (word_cnt == CTRL_WORDS - 1)));

endmodule
